/* edge_cfg.svh */
`ifndef EDGE_CFG_SVH
`define EDGE_CFG_SVH

// Entries in each buffer of the edge data path
`define EDGE_FIFO_DEPTH 16

// Free slots left when almost-full rises
`define EDGE_ALFULL_MARGIN 4

// Byte address width
`define EDGE_ADDR_W 32

// Vertex index width
`define EDGE_VERTEX_W 16

// Bytes per vertex data word
`define DATA_SIZE_READ 8

// Bytes per cache line
`define CACHE_LINE_BYTES 128

`endif

/* edge_data_control.sv */
`include "edge_cfg.svh"

module edge_data_control import edge_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled_in,
	input  logic [31:0]    configure,
	input  addr_t          base_address,
	edge_job_if.consumer   job_if,
	input  read_resp_t     read_resp,
	input  logic           cmd_buffer_alfull,
	input  logic           cmd_bus_grant,
	input  logic           data_request,
	output logic           cmd_bus_request,
	output read_cmd_t      read_cmd,
	output edge_data_t     edge_data,
	output buffer_status_t data_status
);

	localparam addr_t LINE_MASK = addr_t'(`CACHE_LINE_BYTES - 1);

	logic           enabled;
	logic           cmd_enabled;
	logic [31:0]    configure_q;
	addr_t          base_q;
	logic           job_valid_q;
	edge_job_t      job_q;
	edge_job_t      job_head;
	logic           job_pop;
	addr_t          byte_addr;
	logic           cmd_built_valid;
	read_cmd_t      cmd_built;
	vertex_t        built_src;
	read_cmd_t      cmd_head;
	logic           grant_q;
	logic           read_cmd_valid_q;
	read_cmd_t      cmd_out_q;
	logic           resp_valid_q;
	read_resp_t     resp_q;
	vertex_t        tag_src;
	edge_data_t     resp_word;
	logic           data_req_q;
	edge_data_t     data_head;
	logic           edge_data_valid_q;
	edge_data_t     edge_data_q;
	buffer_status_t job_status;
	buffer_status_t cmd_status;
	buffer_status_t tag_status;
	buffer_status_t data_status_int;

	////////////////////////////////////////////////////////////////////////////
	// Enable, configuration and input latches
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled      <= 1'b0;
			cmd_enabled  <= 1'b0;
			configure_q  <= '0;
			job_valid_q  <= 1'b0;
			resp_valid_q <= 1'b0;
			data_req_q   <= 1'b0;
			job_if.request <= 1'b0;
		end else begin
			enabled      <= enabled_in;
			cmd_enabled  <= enabled && (|configure_q);
			configure_q  <= configure;
			job_valid_q  <= job_if.job.valid;
			resp_valid_q <= read_resp.valid;
			data_req_q   <= data_request;
			// Margin covers the two cycle turnaround
			job_if.request <= enabled && !job_status.alfull;
		end
	end

	always_ff @(posedge clock) begin
		base_q <= base_address;
		job_q  <= job_if.job;
		resp_q <= read_resp;
	end

	////////////////////////////////////////////////////////////////////////////
	// Edge job buffer and command build
	////////////////////////////////////////////////////////////////////////////

	assign job_pop = cmd_enabled && !job_status.empty && !cmd_status.alfull
		&& !tag_status.alfull;

	sync_fifo #(
		.WIDTH($bits(edge_job_t)),
		.DEPTH(`EDGE_FIFO_DEPTH)
	) job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid_q),
		.data_in (job_q),
		.pop     (job_pop),
		.data_out(job_head),
		.valid   (job_status.valid),
		.empty   (job_status.empty),
		.full    (job_status.full),
		.alfull  (job_status.alfull)
	);

	// Byte address of the destination's word
	assign byte_addr = base_q + (addr_t'(job_head.dest) << WORD_SHIFT);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			cmd_built_valid <= 1'b0;
		else
			cmd_built_valid <= job_status.valid;
	end

	always_ff @(posedge clock) begin
		cmd_built.valid     <= 1'b1;
		cmd_built.address   <= byte_addr & ~LINE_MASK;
		cmd_built.cl_offset <= byte_addr[LINE_SHIFT-1:WORD_SHIFT];
		cmd_built.tag       <= job_head.dest;
		cmd_built.shared    <= configure_q[0];
		built_src           <= job_head.src;
	end

	////////////////////////////////////////////////////////////////////////////
	// Command buffer and bus arbitration
	////////////////////////////////////////////////////////////////////////////

	sync_fifo #(
		.WIDTH($bits(read_cmd_t)),
		.DEPTH(`EDGE_FIFO_DEPTH)
	) cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_built_valid),
		.data_in (cmd_built),
		.pop     (grant_q),
		.data_out(cmd_head),
		.valid   (cmd_status.valid),
		.empty   (cmd_status.empty),
		.full    (cmd_status.full),
		.alfull  (cmd_status.alfull)
	);

	assign cmd_bus_request = cmd_enabled && !cmd_status.empty && !cmd_buffer_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q          <= 1'b0;
			read_cmd_valid_q <= 1'b0;
		end else begin
			grant_q          <= cmd_bus_grant;
			read_cmd_valid_q <= cmd_status.valid;
		end
	end

	always_ff @(posedge clock) begin
		cmd_out_q <= cmd_head;
	end

	always_comb begin
		read_cmd       = cmd_out_q;
		read_cmd.valid = read_cmd_valid_q;
	end

	////////////////////////////////////////////////////////////////////////////
	// Source tag queue and edge data buffer
	////////////////////////////////////////////////////////////////////////////

	// One src per issued command, responses return in order
	sync_fifo #(
		.WIDTH(VERTEX_W),
		.DEPTH(`EDGE_FIFO_DEPTH)
	) tag_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_built_valid),
		.data_in (built_src),
		.pop     (resp_valid_q),
		.data_out(tag_src),
		.valid   (tag_status.valid),
		.empty   (tag_status.empty),
		.full    (tag_status.full),
		.alfull  (tag_status.alfull)
	);

	always_comb begin
		resp_word.valid = 1'b1;
		resp_word.src   = tag_src;
		resp_word.dest  = resp_q.tag;
		resp_word.data  = resp_q.data;
	end

	sync_fifo #(
		.WIDTH($bits(edge_data_t)),
		.DEPTH(`EDGE_FIFO_DEPTH)
	) data_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (resp_valid_q),
		.data_in (resp_word),
		.pop     (data_req_q),
		.data_out(data_head),
		.valid   (data_status_int.valid),
		.empty   (data_status_int.empty),
		.full    (data_status_int.full),
		.alfull  (data_status_int.alfull)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_data_valid_q <= 1'b0;
			data_status       <= '0;
			data_status.empty <= 1'b1;
		end else begin
			edge_data_valid_q <= data_status_int.valid;
			data_status       <= data_status_int;
		end
	end

	always_ff @(posedge clock) begin
		edge_data_q <= data_head;
	end

	always_comb begin
		edge_data       = edge_data_q;
		edge_data.valid = edge_data_valid_q;
	end

endmodule

/* edge_data_unit.sv */
module edge_data_unit import edge_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled_in,
	input  logic [31:0]    configure,
	input  addr_t          base_address,
	input  edge_run_t      run_in,
	output logic           run_ready,
	input  read_resp_t     read_resp,
	input  logic           cmd_buffer_alfull,
	input  logic           cmd_bus_grant,
	input  logic           data_request,
	output logic           cmd_bus_request,
	output read_cmd_t      read_cmd,
	output edge_data_t     edge_data,
	output buffer_status_t data_status
);

	// Job link between the splitter and the data control
	edge_job_if job_link ();

	edge_run_splitter splitter (
		.clock    (clock),
		.rstn     (rstn),
		.run_in   (run_in),
		.run_ready(run_ready),
		.job_if   (job_link.producer)
	);

	edge_data_control control (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.configure        (configure),
		.base_address     (base_address),
		.job_if           (job_link.consumer),
		.read_resp        (read_resp),
		.cmd_buffer_alfull(cmd_buffer_alfull),
		.cmd_bus_grant    (cmd_bus_grant),
		.data_request     (data_request),
		.cmd_bus_request  (cmd_bus_request),
		.read_cmd         (read_cmd),
		.edge_data        (edge_data),
		.data_status      (data_status)
	);

endmodule

/* edge_pkg.sv */
`include "edge_cfg.svh"

package edge_pkg;

	localparam int VERTEX_W    = `EDGE_VERTEX_W;
	localparam int COUNT_W     = `EDGE_VERTEX_W + 1;
	localparam int ADDR_W      = `EDGE_ADDR_W;
	localparam int DATA_W      = `DATA_SIZE_READ * 8;
	localparam int WORD_SHIFT  = $clog2(`DATA_SIZE_READ);
	localparam int LINE_SHIFT  = $clog2(`CACHE_LINE_BYTES);
	localparam int CL_OFFSET_W = LINE_SHIFT - WORD_SHIFT;

	typedef logic [VERTEX_W-1:0] vertex_t;
	typedef logic [COUNT_W-1:0]  count_t;
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [DATA_W-1:0]   data_t;

	// Contiguous run of destinations from one source
	typedef struct packed {
		logic    valid;
		vertex_t src;
		vertex_t dest_first;
		count_t  count;
	} edge_run_t;

	typedef struct packed {
		logic    valid;
		vertex_t src;
		vertex_t dest;
	} edge_job_t;

	// Line aligned read, tag is the destination vertex
	typedef struct packed {
		logic                   valid;
		addr_t                  address;
		logic [CL_OFFSET_W-1:0] cl_offset;
		vertex_t                tag;
		logic                   shared;
	} read_cmd_t;

	typedef struct packed {
		logic    valid;
		vertex_t tag;
		data_t   data;
	} read_resp_t;

	typedef struct packed {
		logic    valid;
		vertex_t src;
		vertex_t dest;
		data_t   data;
	} edge_data_t;

	typedef struct packed {
		logic valid;
		logic empty;
		logic full;
		logic alfull;
	} buffer_status_t;

endpackage

interface edge_job_if import edge_pkg::*; ();

	edge_job_t job;
	logic      request;

	modport producer (output job, input request);
	modport consumer (input job, output request);

endinterface

/* edge_run_splitter.sv */
module edge_run_splitter import edge_pkg::*; (
	input  logic      clock,
	input  logic      rstn,
	input  edge_run_t run_in,
	output logic      run_ready,
	edge_job_if.producer job_if
);

	logic    active;
	logic    next_active;
	logic    take_run;
	logic    emit;
	vertex_t src_q;
	vertex_t dest_q;
	count_t  remaining;

	assign take_run = run_in.valid && run_ready;
	assign emit     = active && job_if.request;

	// One job per requested cycle
	always_comb begin
		job_if.job.valid = emit;
		job_if.job.src   = src_q;
		job_if.job.dest  = dest_q;
	end

	// A zero count run never leaves idle
	always_comb begin
		next_active = active;
		if (take_run)
			next_active = (run_in.count != '0);
		else if (emit && remaining == count_t'(1))
			next_active = 1'b0;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active    <= 1'b0;
			run_ready <= 1'b0;
			remaining <= '0;
		end else begin
			active    <= next_active;
			run_ready <= !next_active;
			if (take_run)
				remaining <= run_in.count;
			else if (emit)
				remaining <= remaining - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (take_run) begin
			src_q  <= run_in.src;
			dest_q <= run_in.dest_first;
		end else if (emit) begin
			dest_q <= dest_q + 1'b1;
		end
	end

endmodule

/* filelist.f */
+incdir+.
edge_pkg.sv
sync_fifo.sv
edge_run_splitter.sv
edge_data_control.sv
edge_data_unit.sv
tb_clock.sv
tb_checker.sv
tb_asserts.sv
tb_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f filelist.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	&& grep -qxF '** PASS **' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

/* sync_fifo.sv */
`include "edge_cfg.svh"

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);
	localparam logic [PTR_W:0] ALFULL_COUNT = (PTR_W + 1)'(DEPTH - `EDGE_ALFULL_MARGIN);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Head entry falls through to the output
	assign data_out = mem[rd_ptr];
	assign valid    = do_pop;
	assign empty    = (count == '0);
	assign full     = (count == FULL_COUNT);
	assign alfull   = (count >= ALFULL_COUNT);

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* tb_asserts.sv */
module tb_asserts (
	input logic clock,
	input logic rstn,
	input logic cmd_bus_grant,
	input logic read_cmd_valid,
	input logic edge_data_valid,
	input logic job_push,
	input logic job_full,
	input logic cmd_push,
	input logic cmd_full,
	input logic tag_full,
	input logic tag_empty,
	input logic data_push,
	input logic data_full
);

	// Registered grant pops the command one cycle before it leaves
	read_cmd_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> $past(cmd_bus_grant, 2))
		else $error("read_cmd.valid without a grant two cycles before");

	job_push_not_full: assert property (@(posedge clock) disable iff (!rstn)
		job_push |-> !job_full)
		else $error("push into full job buffer");

	cmd_push_not_full: assert property (@(posedge clock) disable iff (!rstn)
		cmd_push |-> !cmd_full)
		else $error("push into full command buffer");

	tag_push_not_full: assert property (@(posedge clock) disable iff (!rstn)
		cmd_push |-> !tag_full)
		else $error("push into full tag queue");

	data_push_not_full: assert property (@(posedge clock) disable iff (!rstn)
		data_push |-> !data_full)
		else $error("push into full data buffer");

	// Every response takes the src of an issued command
	resp_has_src: assert property (@(posedge clock) disable iff (!rstn)
		data_push |-> !tag_empty)
		else $error("read response with no issued command");

	edge_data_quiet_in_reset: assert property (@(posedge clock)
		(!rstn || !$past(rstn)) |-> !edge_data_valid)
		else $error("edge_data.valid high during or right after reset");

endmodule

/* tb_checker.sv */
`include "edge_cfg.svh"

module tb_checker import edge_pkg::*; (
	input logic           clock,
	input logic           rstn,
	input read_cmd_t      read_cmd,
	input edge_data_t     edge_data,
	input buffer_status_t data_status,
	input addr_t          base_address,
	input logic [31:0]    configure
);

	int error_count = 0;
	int cmd_count = 0;
	int data_count = 0;
	edge_data_t exp_q[$];

	task automatic expect_edge(input vertex_t src, input vertex_t dest, input data_t data);
		exp_q.push_back('{valid: 1'b1, src: src, dest: dest, data: data});
	endtask

	task automatic value_error(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("Error at %0t: %s got %h expected %h", $time, name, got, want);
		error_count++;
	endtask

	// Data buffer flags expected for a given entry count
	task automatic check_status(input int entries);
		logic want_full;
		logic want_alfull;
		logic want_empty;
		want_full   = (entries == `EDGE_FIFO_DEPTH);
		want_alfull = (entries >= `EDGE_FIFO_DEPTH - `EDGE_ALFULL_MARGIN);
		want_empty  = (entries == 0);
		if (data_status.full != want_full)
			value_error("data_status.full", 64'(data_status.full), 64'(want_full));
		if (data_status.alfull != want_alfull)
			value_error("data_status.alfull", 64'(data_status.alfull), 64'(want_alfull));
		if (data_status.empty != want_empty)
			value_error("data_status.empty", 64'(data_status.empty), 64'(want_empty));
	endtask

	// Registered outputs sampled on the falling edge
	always @(negedge clock) begin : compare
		edge_data_t want;
		addr_t      word_addr;
		addr_t      dest_addr;
		if (rstn && read_cmd.valid) begin
			cmd_count++;
			word_addr = read_cmd.address + (addr_t'(read_cmd.cl_offset) << 3);
			dest_addr = base_address + (addr_t'(read_cmd.tag) << 3);
			if (read_cmd.address[6:0] != 7'd0)
				value_error("read_cmd.address[6:0]", 64'(read_cmd.address[6:0]), 64'd0);
			if (word_addr != dest_addr)
				value_error("read_cmd word address", 64'(word_addr), 64'(dest_addr));
			if (read_cmd.shared != configure[0])
				value_error("read_cmd.shared", 64'(read_cmd.shared), 64'(configure[0]));
		end
		if (rstn && edge_data.valid) begin
			data_count++;
			if (exp_q.size() == 0) begin
				$display("Error at %0t: edge_data word arrived with no edge left to expect",
					$time);
				error_count++;
			end else begin
				want = exp_q.pop_front();
				if (edge_data.src != want.src)
					value_error("edge_data.src", 64'(edge_data.src), 64'(want.src));
				if (edge_data.dest != want.dest)
					value_error("edge_data.dest", 64'(edge_data.dest), 64'(want.dest));
				if (edge_data.data != want.data)
					value_error("edge_data.data", edge_data.data, want.data);
			end
		end
	end

endmodule

/* tb_clock.sv */
module tb_clock (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Reset held for two rising edges
	initial begin
		rstn = 1'b0;
		repeat (2) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

/* tb_top.sv */
module tb_top import edge_pkg::*; ();

	logic           clock;
	logic           rstn;
	logic           enabled_in;
	logic [31:0]    configure;
	addr_t          base_address;
	edge_run_t      run_in;
	logic           run_ready;
	read_resp_t     read_resp;
	logic           cmd_buffer_alfull;
	logic           cmd_bus_grant;
	logic           data_request;
	logic           cmd_bus_request;
	read_cmd_t      read_cmd;
	edge_data_t     edge_data;
	buffer_status_t data_status;

	logic [31:0] rng = 32'h2d16;
	logic        grant_hold = 1'b0;
	logic        data_hold = 1'b0;
	int          resp_limit = 16;
	int          resp_sent = 0;
	int          total_edges = 0;
	int          tb_errors = 0;
	addr_t       pend_addr[$];
	vertex_t     pend_tag[$];

	tb_clock clock_gen (.clock(clock), .rstn(rstn));

	edge_data_unit dut0 (.*);

	tb_checker checker0 (
		.clock       (clock),
		.rstn        (rstn),
		.read_cmd    (read_cmd),
		.edge_data   (edge_data),
		.data_status (data_status),
		.base_address(base_address),
		.configure   (configure)
	);

	bind edge_data_control tb_asserts asserts0 (
		.clock          (clock),
		.rstn           (rstn),
		.cmd_bus_grant  (cmd_bus_grant),
		.read_cmd_valid (read_cmd.valid),
		.edge_data_valid(edge_data.valid),
		.job_push       (job_valid_q),
		.job_full       (job_status.full),
		.cmd_push       (cmd_built_valid),
		.cmd_full       (cmd_status.full),
		.tag_full       (tag_status.full),
		.tag_empty      (tag_status.empty),
		.data_push      (resp_valid_q),
		.data_full      (data_status_int.full)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_below(input int n);
		rng = xorshift(rng);
		return int'(rng % 32'(n));
	endfunction

	// Memory contents as a fixed mix of the byte address
	function automatic data_t mem_word(input addr_t addr);
		return {addr ^ 32'h9e37_79b9, (addr * 32'h0001_85eb) ^ 32'hc2b2_ae35};
	endfunction

	// Reference for the word that belongs to an edge's destination
	function automatic data_t expected_word(input vertex_t dest);
		return mem_word(base_address + (addr_t'(dest) << 3));
	endfunction

	// Commands are answered in issue order
	always @(negedge clock) begin
		if (rstn && read_cmd.valid) begin
			pend_addr.push_back(read_cmd.address + (addr_t'(read_cmd.cl_offset) << 3));
			pend_tag.push_back(read_cmd.tag);
		end
	end

	// Memory responder that never returns more than the data buffer holds
	initial begin : responder
		int gap;
		forever begin
			@(negedge clock);
			if (pend_addr.size() != 0 && resp_sent - checker0.data_count < resp_limit) begin
				gap = rand_below(4);
				repeat (gap) @(posedge clock);
				@(posedge clock);
				read_resp <= '{valid: 1'b1, tag: pend_tag.pop_front(),
					data: mem_word(pend_addr.pop_front())};
				resp_sent++;
				@(posedge clock);
				read_resp.valid <= 1'b0;
			end
		end
	end

	// Bus arbiter with random grant delays
	initial begin : arbiter
		forever begin
			@(negedge clock);
			if (!grant_hold && cmd_bus_request && rand_below(3) == 0) begin
				@(posedge clock);
				cmd_bus_grant <= 1'b1;
				@(posedge clock);
				cmd_bus_grant <= 1'b0;
				// Wait for the pop to show in cmd_bus_request
				@(posedge clock);
			end
		end
	end

	initial begin : consumer
		forever begin
			@(posedge clock);
			data_request <= !data_hold && (rand_below(4) != 0);
		end
	end

	task automatic submit_run(input vertex_t src, input vertex_t first, input int count);
		int n;
		vertex_t dest;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!run_ready && n < 2000);
		if (!run_ready) begin
			$display("Timeout: run_ready never rose for run from src %h", src);
			tb_errors++;
		end
		@(posedge clock);
		run_in <= '{valid: 1'b1, src: src, dest_first: first, count: count_t'(count)};
		@(posedge clock);
		run_in.valid <= 1'b0;
		for (int i = 0; i < count; i++) begin
			dest = first + vertex_t'(i);
			checker0.expect_edge(src, dest, expected_word(dest));
			total_edges++;
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (checker0.data_count < total_edges && n < 20000) begin
			@(negedge clock);
			n++;
		end
		if (checker0.data_count < total_edges) begin
			$display("Timeout: %0d of %0d edges arrived", checker0.data_count, total_edges);
			tb_errors++;
		end
	endtask

	// Waits until the data buffer holds the given number of words
	task automatic wait_level(input int entries);
		int n;
		n = 0;
		while (resp_sent - checker0.data_count != entries && n < 5000) begin
			@(negedge clock);
			n++;
		end
		if (resp_sent - checker0.data_count != entries) begin
			$display("Timeout: data buffer never reached %0d words", entries);
			tb_errors++;
		end
		repeat (4) @(negedge clock);
	endtask

	initial begin : stimulus
		int n;
		int low_cycles;
		enabled_in        = 1'b0;
		configure         = 32'h0;
		base_address      = 32'h0004_1238;
		run_in            = '0;
		read_resp         = '0;
		cmd_buffer_alfull = 1'b0;
		cmd_bus_grant     = 1'b0;
		data_request      = 1'b0;
		n = 0;
		while (rstn !== 1'b1 && n < 100) begin
			@(negedge clock);
			n++;
		end
		if (rstn !== 1'b1) begin
			$display("Timeout: reset was never released");
			tb_errors++;
		end
		@(posedge clock);
		enabled_in <= 1'b1;

		// Jobs pile up while the configuration word is zero
		submit_run(16'h0005, 16'h0100, 20);
		repeat (60) @(posedge clock);
		if (checker0.cmd_count != 0) begin
			$display("Commands were issued while the configuration word was zero");
			tb_errors++;
		end
		configure <= 32'h1;

		// Zero count run followed by normal and random runs
		submit_run(16'h0007, 16'h0200, 0);
		submit_run(16'h0008, vertex_t'(rand_below(65536)), 5);
		for (int r = 0; r < 6; r++)
			submit_run(vertex_t'(rand_below(65536)), vertex_t'(rand_below(65536)),
				rand_below(10));

		// Long stretch without grants
		grant_hold = 1'b1;
		submit_run(16'h0009, vertex_t'(rand_below(65536)), 12);
		n = 0;
		while (!cmd_bus_request && n < 200) begin
			@(negedge clock);
			n++;
		end
		low_cycles = 0;
		repeat (200) begin
			@(negedge clock);
			if (!cmd_bus_request)
				low_cycles++;
		end
		if (low_cycles != 0) begin
			$display("cmd_bus_request was low for %0d cycles while grants were withheld",
				low_cycles);
			tb_errors++;
		end

		// Downstream command buffer nearly full
		@(posedge clock);
		cmd_buffer_alfull <= 1'b1;
		repeat (2) @(negedge clock);
		if (cmd_bus_request) begin
			$display("cmd_bus_request stayed high while cmd_buffer_alfull was set");
			tb_errors++;
		end
		@(posedge clock);
		cmd_buffer_alfull <= 1'b0;
		grant_hold = 1'b0;
		wait_drained();

		// Data buffer fills while nobody asks for data
		data_hold = 1'b1;
		repeat (4) @(negedge clock);
		checker0.check_status(0);
		resp_limit = 12;
		submit_run(16'h000a, vertex_t'(rand_below(65536)), 30);
		wait_level(12);
		checker0.check_status(12);
		resp_limit = 16;
		wait_level(16);
		checker0.check_status(16);
		data_hold = 1'b0;
		wait_drained();

		// Non-allocating reads
		@(posedge clock);
		configure <= 32'h2;
		repeat (4) @(posedge clock);
		submit_run(16'h000b, vertex_t'(rand_below(65536)), 6);
		wait_drained();
		repeat (20) @(negedge clock);
		if (checker0.cmd_count != total_edges) begin
			$display("Issued %0d read commands for %0d edges", checker0.cmd_count,
				total_edges);
			tb_errors++;
		end
		checker0.check_status(0);

		$display("Edges %0d, checker errors %0d, testbench errors %0d", total_edges,
			checker0.error_count, tb_errors);
		if (checker0.error_count == 0 && tb_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
